//--- sources.f
+incdir+.
maze_router_pkg.sv
wave_grid.sv
path_retracer.sv
weight_map.sv
route_ctrl.sv
maze_router.sv
tb_maze_router.sv

//--- Makefile
# Verilator build and run of the maze router testbench
VERILATOR ?= verilator
TOP       ?= tb_maze_router
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_route_model.svh
// reference model of the maze router included inside tb_maze_router
// needs grid_dim from maze_router_pkg visible where it is included
// distances come from a plain breadth-first search over the model map
`ifndef tb_route_model_svh
`define tb_route_model_svh

bit blk_map  [grid_dim][grid_dim]; // [y][x] with 1 for an obstacle or an earlier path
int wt_map   [grid_dim][grid_dim];
int dist_map [grid_dim][grid_dim]; // -1 where the search never got

function automatic bit in_grid(input int x, input int y);
	return (x >= 0) && (x < grid_dim) && (y >= 0) && (y < grid_dim);
endfunction

// routes one net in the model and blocks its path cells
task automatic route_in_model(input int sx, input int sy, input int ex, input int ey,
                              output bit routed, output int cost);
	int q[$];
	int dx[4] = '{0, 0, 1, -1}; // down, up, right, left
	int dy[4] = '{1, -1, 0, 0};
	int idx;
	int cx;
	int cy;
	int nx;
	int ny;
	int want;
	bit found;
	routed = 1'b0;
	cost   = 0;
	blk_map[sy][sx] = 1'b0; // seed frees start and end
	blk_map[ey][ex] = 1'b0;
	for (int y = 0; y < grid_dim; y++) begin
		for (int x = 0; x < grid_dim; x++) begin
			dist_map[y][x] = -1;
		end
	end
	dist_map[sy][sx] = 0;
	q.push_back(sy * grid_dim + sx);
	while (q.size() > 0) begin
		idx = q.pop_front();
		cy  = idx / grid_dim;
		cx  = idx % grid_dim;
		for (int k = 0; k < 4; k++) begin
			nx = cx + dx[k];
			ny = cy + dy[k];
			if (in_grid(nx, ny) && !blk_map[ny][nx] && dist_map[ny][nx] < 0) begin
				dist_map[ny][nx] = dist_map[cy][cx] + 1;
				q.push_back(ny * grid_dim + nx);
			end
		end
	end
	if (dist_map[ey][ex] < 0) return; // unreachable so nothing gets blocked
	routed = 1'b1;
	cx     = ex;
	cy     = ey;
	// walk back one ring per cell
	for (int n = 0; n < grid_dim * grid_dim; n++) begin
		blk_map[cy][cx] = 1'b1;
		if (cx == sx && cy == sy) break;
		if (!(cx == ex && cy == ey)) cost += wt_map[cy][cx];
		want  = dist_map[cy][cx] - 1;
		found = 1'b0;
		for (int k = 0; k < 4 && !found; k++) begin
			nx = cx + dx[k];
			ny = cy + dy[k];
			if (in_grid(nx, ny) && dist_map[ny][nx] == want) begin
				found = 1'b1;
				cx    = nx;
				cy    = ny;
			end
		end
	end
endtask

`endif

//--- tb_maze_router.sv
// testbench for the maze router
// maps and nets come from a 16-bit LFSR, expected results from the model
// inputs change on the falling edge and outputs are sampled there as well
`default_nettype none

module tb_maze_router;

	timeunit 1ns;
	timeprecision 100ps;

	import maze_router_pkg::*;

	localparam int wait_limit = 2000; // cycles, above any fill plus retrace

	logic         clk;
	logic         rst_n;
	logic         map_we;
	coord_t       map_row;
	row_bits_t    map_blocked;
	row_weights_t map_weights;
	logic         req;
	route_req_t   route_req;
	logic         ack;
	route_rsp_t   route_rsp;

	logic [15:0] lfsr_state;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          test_errors;   // error count when the test began
	bit          timed_out;

	`include "tb_route_model.svh"

	maze_router DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.map_we      (map_we),
		.map_row     (map_row),
		.map_blocked (map_blocked),
		.map_weights (map_weights),
		.req         (req),
		.route_req   (route_req),
		.ack         (ack),
		.route_rsp   (route_rsp)
	);

	always #2 clk = ~clk;

	// ======================================================================
	// random numbers and checks
	// ======================================================================
	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic int rand_bits(input int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = (r << 1) | int'(lfsr_state[0]);
		end
		return r;
	endfunction

	function automatic point_t rand_point();
		point_t p;
		p.x = coord_t'(rand_bits(4));
		p.y = coord_t'(rand_bits(4));
		return p;
	endfunction

	task automatic expect_equal(input string name, input int got, input int exp);
		assert (got == exp) else begin
			$display("** Error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic begin_test();
		test_errors = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != test_errors || timed_out) begin
			tests_failed++;
			$display("test %0d %s: failed, %0d errors", tests_run, name, errors - test_errors);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
	endtask

	// ======================================================================
	// map and request drivers
	// ======================================================================
	task automatic fill_map(input bit obstacles);
		for (int y = 0; y < grid_dim; y++) begin
			for (int x = 0; x < grid_dim; x++) begin
				blk_map[y][x] = obstacles && (rand_bits(2) == 0); // about 1 in 4
				wt_map[y][x]  = rand_bits(4);
			end
		end
	endtask

	task automatic load_map();
		for (int y = 0; y < grid_dim; y++) begin
			@(negedge clk);
			map_we  = 1'b1;
			map_row = coord_t'(y);
			for (int x = 0; x < grid_dim; x++) begin
				map_blocked[x]                      = blk_map[y][x];
				map_weights[x*weight_w +: weight_w] = weight_t'(wt_map[y][x]);
			end
		end
		@(negedge clk);
		map_we = 1'b0;
	endtask

	// four-phase request, req held for extra cycles after ack
	task automatic drive_request(input point_t s, input point_t e, input int extra,
	                             output route_rsp_t rsp);
		int         cycles;
		route_rsp_t held;
		rsp = '0;
		if (timed_out) return;
		@(negedge clk);
		expect_equal("ack", int'(ack), 0); // idle before the request
		route_req.start_pt = s;
		route_req.end_pt   = e;
		req                = 1'b1;
		cycles             = 0;
		while (!ack && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!ack) begin
			$display("timeout: ack did not rise within %0d cycles of req", wait_limit);
			timed_out = 1'b1;
			return;
		end
		held = route_rsp;
		for (int i = 0; i < extra; i++) begin
			@(negedge clk);
			expect_equal("ack", int'(ack), 1);
			expect_equal("route_rsp", int'(route_rsp), int'(held));
		end
		req    = 1'b0;
		cycles = 0;
		while (ack && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
			if (ack) expect_equal("route_rsp", int'(route_rsp), int'(held));
		end
		if (ack) begin
			$display("timeout: ack stayed high %0d cycles after req dropped", wait_limit);
			timed_out = 1'b1;
			return;
		end
		expect_equal("ack fall delay", cycles, 1);
		rsp = held;
	endtask

	task automatic route_and_check(input point_t s, input point_t e, input int extra,
	                               output bit routed);
		route_rsp_t rsp;
		bit         exp_routed;
		int         exp_cost;
		routed = 1'b0;
		drive_request(s, e, extra, rsp);
		if (timed_out) return;
		route_in_model(int'(s.x), int'(s.y), int'(e.x), int'(e.y), exp_routed, exp_cost);
		expect_equal("route_rsp.routed", int'(rsp.routed), int'(exp_routed));
		expect_equal("route_rsp.cost", int'(rsp.cost), exp_cost);
		routed = rsp.routed;
	endtask

	// ======================================================================
	// tests
	// ======================================================================
	task automatic test_reset_state();
		begin_test();
		@(negedge clk);
		expect_equal("ack", int'(ack), 0);
		expect_equal("route_rsp", int'(route_rsp), 0);
		end_test("reset state");
	endtask

	// fresh open map per net, so every net can route
	task automatic test_open_map();
		point_t s;
		point_t e;
		bit     routed;
		begin_test();
		for (int n = 0; n < 6 && !timed_out; n++) begin
			fill_map(1'b0);
			load_map();
			s = rand_point();
			e = rand_point();
			route_and_check(s, e, 0, routed);
			expect_equal("route_rsp.routed", int'(routed), 1);
		end
		end_test("open map");
	endtask

	task automatic test_obstacles();
		point_t s;
		point_t e;
		bit     routed;
		begin_test();
		for (int m = 0; m < 4 && !timed_out; m++) begin
			fill_map(1'b1);
			load_map();
			for (int n = 0; n < 3; n++) begin
				s = rand_point();
				e = rand_point();
				route_and_check(s, e, 0, routed);
			end
		end
		end_test("obstacles");
	endtask

	task automatic test_walled_end();
		point_t s;
		point_t e;
		int     ex;
		int     ey;
		bit     routed;
		begin_test();
		fill_map(1'b0);
		e  = rand_point();
		ex = int'(e.x);
		ey = int'(e.y);
		if (ey < grid_dim - 1) blk_map[ey+1][ex] = 1'b1;
		if (ey > 0) blk_map[ey-1][ex] = 1'b1;
		if (ex < grid_dim - 1) blk_map[ey][ex+1] = 1'b1;
		if (ex > 0) blk_map[ey][ex-1] = 1'b1;
		load_map();
		s.x = e.x ^ coord_t'(8); // eight columns away, outside the wall
		s.y = e.y;
		route_and_check(s, e, 0, routed);
		expect_equal("route_rsp.routed", int'(routed), 0);
		// same map, no reload
		s = rand_point();
		e = rand_point();
		route_and_check(s, e, 0, routed);
		end_test("walled end");
	endtask

	task automatic test_net_sequence();
		point_t s;
		point_t e;
		bit     routed;
		begin_test();
		fill_map(1'b0);
		load_map();
		for (int n = 0; n < 8 && !timed_out; n++) begin
			s = rand_point();
			e = rand_point();
			route_and_check(s, e, 0, routed);
		end
		end_test("net sequence");
	endtask

	task automatic test_handshake_hold();
		point_t s;
		point_t e;
		int     extra;
		bit     routed;
		begin_test();
		fill_map(1'b0);
		load_map();
		for (int n = 0; n < 6 && !timed_out; n++) begin
			s     = rand_point();
			e     = rand_point();
			extra = rand_bits(3);
			route_and_check(s, e, extra, routed);
		end
		end_test("handshake hold");
	endtask

	initial begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		map_we       = 1'b0;
		map_row      = '0;
		map_blocked  = '0;
		map_weights  = '0;
		req          = 1'b0;
		route_req    = '0;
		lfsr_state   = 16'h0001;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		test_errors  = 0;
		timed_out    = 1'b0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;

		test_reset_state();
		if (!timed_out) test_open_map();
		if (!timed_out) test_obstacles();
		if (!timed_out) test_walled_end();
		if (!timed_out) test_net_sequence();
		if (!timed_out) test_handshake_hold();

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && !timed_out) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- maze_router.sv
// maze router top level
// map rows may only be written while req and ack are both low
// requests follow a four-phase req/ack handshake, one net at a time
// routed nets stay blocked until the map is reloaded
`default_nettype none

module maze_router (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire                            map_we,
	input  wire maze_router_pkg::coord_t       map_row,
	input  wire maze_router_pkg::row_bits_t    map_blocked,
	input  wire maze_router_pkg::row_weights_t map_weights,
	input  wire                            req,
	input  wire maze_router_pkg::route_req_t   route_req,
	output logic                           ack,
	output maze_router_pkg::route_rsp_t        route_rsp
);

	import maze_router_pkg::*;

	// ======================================================================
	// internal connections
	// ======================================================================
	route_req_t net;            // latched request
	logic       seed;
	logic       grow;
	logic       clear_wave;
	logic       retrace_start;
	logic       end_reached;
	logic       stalled;
	logic       retrace_done;
	cost_t      path_cost;
	cell_t      nbr_down;
	cell_t      nbr_up;
	cell_t      nbr_right;
	cell_t      nbr_left;
	cell_t      wave_label;
	point_t     cur_pt;
	logic       mark;
	point_t     wt_pt;
	weight_t    wt;

	route_ctrl u_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.req           (req),
		.route_req     (route_req),
		.ack           (ack),
		.route_rsp     (route_rsp),
		.net           (net),
		.seed          (seed),
		.grow          (grow),
		.clear_wave    (clear_wave),
		.retrace_start (retrace_start),
		.end_reached   (end_reached),
		.stalled       (stalled),
		.retrace_done  (retrace_done),
		.path_cost     (path_cost)
	);

	wave_grid u_grid (
		.clk         (clk),
		.rst_n       (rst_n),
		.map_we      (map_we),
		.map_row     (map_row),
		.map_blocked (map_blocked),
		.net         (net),
		.seed        (seed),
		.grow        (grow),
		.clear_wave  (clear_wave),
		.mark        (mark),
		.cur_pt      (cur_pt),
		.end_reached (end_reached),
		.stalled     (stalled),
		.nbr_down    (nbr_down),
		.nbr_up      (nbr_up),
		.nbr_right   (nbr_right),
		.nbr_left    (nbr_left),
		.wave_label  (wave_label)
	);

	path_retracer u_retracer (
		.clk           (clk),
		.rst_n         (rst_n),
		.retrace_start (retrace_start),
		.net           (net),
		.nbr_down      (nbr_down),
		.nbr_up        (nbr_up),
		.nbr_right     (nbr_right),
		.nbr_left      (nbr_left),
		.wave_label    (wave_label),
		.cur_pt        (cur_pt),
		.mark          (mark),
		.wt_pt         (wt_pt),
		.wt            (wt),
		.done          (retrace_done),
		.path_cost     (path_cost)
	);

	weight_map u_weights (
		.clk         (clk),
		.rst_n       (rst_n),
		.map_we      (map_we),
		.map_row     (map_row),
		.map_weights (map_weights),
		.wt_pt       (wt_pt),
		.wt          (wt)
	);

endmodule

`default_nettype wire

//--- route_ctrl.sv
// request control for the maze router
// a new request is taken only in idle, i.e. after ack has dropped
// an unreachable end point gives routed 0 and cost 0
`default_nettype none

module route_ctrl (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          req,
	input  wire maze_router_pkg::route_req_t route_req,
	output logic                         ack,
	output maze_router_pkg::route_rsp_t      route_rsp,
	output maze_router_pkg::route_req_t      net,
	output logic                         seed,
	output logic                         grow,
	output logic                         clear_wave,
	output logic                         retrace_start,
	input  wire                          end_reached,
	input  wire                          stalled,
	input  wire                          retrace_done,
	input  wire maze_router_pkg::cost_t      path_cost
);

	import maze_router_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_nxt;

	// ======================================================================
	// routing FSM
	// ======================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle:    if (req) state_nxt = st_seed;
			st_seed:    state_nxt = st_fill;
			st_fill: begin
				if (end_reached) begin
					state_nxt = st_retrace;
				end else if (stalled) begin
					state_nxt = st_clear; // no path, skip retrace
				end
			end
			st_retrace: if (retrace_done) state_nxt = st_clear;
			st_clear:   state_nxt = st_ack;
			st_ack:     if (!req) state_nxt = st_idle;
			default:    state_nxt = st_idle;
		endcase
	end

	// grid and retracer commands
	assign seed          = (state == st_seed);
	assign grow          = (state == st_fill) && !end_reached && !stalled;
	assign retrace_start = (state == st_fill) && end_reached;
	assign clear_wave    = (state == st_clear);
	assign ack           = (state == st_ack);

	// request latch
	always_ff @(posedge clk) begin
		if (state == st_idle && req) begin
			net <= route_req;
		end
	end

	// response, held until the next net finishes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			route_rsp <= '0;
		end else if (state == st_fill && !end_reached && stalled) begin
			route_rsp <= '0;
		end else if (state == st_retrace && retrace_done) begin
			route_rsp.routed <= 1'b1;
			route_rsp.cost   <= path_cost;
		end
	end

endmodule

`default_nettype wire

//--- weight_map.sv
// per-cell weight store, written a row at a time
// unloaded cells read as weight 0 after reset
`default_nettype none

module weight_map (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire                            map_we,
	input  wire maze_router_pkg::coord_t       map_row,
	input  wire maze_router_pkg::row_weights_t map_weights,
	input  wire maze_router_pkg::point_t       wt_pt,
	output maze_router_pkg::weight_t           wt
);

	import maze_router_pkg::*;

	row_weights_t rows [grid_dim];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int y = 0; y < grid_dim; y++) begin
				rows[y] <= '0;
			end
		end else if (map_we) begin
			rows[map_row] <= map_weights;
		end
	end

	// nibble of column x
	assign wt = rows[wt_pt.y][int'(wt_pt.x) * weight_w +: weight_w];

endmodule

`default_nettype wire

//--- path_retracer.sv
// backward walk from the end point to the start point
// one path cell per cycle, marked in the same cycle it is visited
// direction priority down, up, right, left
// start and end weights are not part of the cost
`default_nettype none

module path_retracer (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          retrace_start,
	input  wire maze_router_pkg::route_req_t net,
	input  wire maze_router_pkg::cell_t      nbr_down,
	input  wire maze_router_pkg::cell_t      nbr_up,
	input  wire maze_router_pkg::cell_t      nbr_right,
	input  wire maze_router_pkg::cell_t      nbr_left,
	input  wire maze_router_pkg::cell_t      wave_label,
	output maze_router_pkg::point_t          cur_pt,
	output logic                         mark,
	output maze_router_pkg::point_t          wt_pt,
	input  wire maze_router_pkg::weight_t    wt,
	output logic                         done,
	output maze_router_pkg::cost_t           path_cost
);

	import maze_router_pkg::*;

	logic   active;
	logic   at_start;
	logic   at_end;
	point_t next_pt;

	assign at_start = (cur_pt == net.start_pt);
	assign at_end   = (cur_pt == net.end_pt);
	assign mark     = active;
	assign done     = active && at_start;
	assign wt_pt    = cur_pt;

	// next cell one ring closer to the start
	always_comb begin
		next_pt = cur_pt;
		if (nbr_down == wave_label) begin
			next_pt.y = cur_pt.y + coord_t'(1);
		end else if (nbr_up == wave_label) begin
			next_pt.y = cur_pt.y - coord_t'(1);
		end else if (nbr_right == wave_label) begin
			next_pt.x = cur_pt.x + coord_t'(1);
		end else if (nbr_left == wave_label) begin
			next_pt.x = cur_pt.x - coord_t'(1);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active    <= 1'b0;
			cur_pt    <= '0;
			path_cost <= '0;
		end else if (retrace_start) begin
			active    <= 1'b1;
			cur_pt    <= net.end_pt;
			path_cost <= '0;
		end else if (active) begin
			if (at_start) begin
				active <= 1'b0; // start marked, walk done
			end else begin
				cur_pt <= next_pt;
			end
			if (!at_start && !at_end) begin
				path_cost <= path_cost + cost_t'(wt);
			end
		end
	end

endmodule

`default_nettype wire

//--- wave_grid.sv
// cell label array of the maze router
// labels have no reset, the whole map must be loaded before routing
// only one of map_we, seed, grow, clear_wave and mark is expected per cycle
// cells outside the grid read as blocked
`default_nettype none

module wave_grid (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           map_we,
	input  wire maze_router_pkg::coord_t      map_row,
	input  wire maze_router_pkg::row_bits_t   map_blocked,
	input  wire maze_router_pkg::route_req_t  net,
	input  wire                           seed,
	input  wire                           grow,
	input  wire                           clear_wave,
	input  wire                           mark,
	input  wire maze_router_pkg::point_t      cur_pt,
	output logic                          end_reached,
	output logic                          stalled,
	output maze_router_pkg::cell_t            nbr_down,
	output maze_router_pkg::cell_t            nbr_up,
	output maze_router_pkg::cell_t            nbr_right,
	output maze_router_pkg::cell_t            nbr_left,
	output maze_router_pkg::cell_t            wave_label
);

	import maze_router_pkg::*;

	cell_t               grid [grid_dim][grid_dim]; // [y][x]
	logic [1:0]          step;                      // wave distance mod 4
	logic [1:0]          step_next;
	logic [1:0]          step_prev;
	cell_t               grow_label;
	logic [grid_dim+1:0] wpad [grid_dim+2];         // wave bits, one cell border
	logic [grid_dim-1:0] cand [grid_dim];           // free cells the wave hits

	assign step_next  = step + 2'd1;
	assign step_prev  = step - 2'd1;
	assign grow_label = step_next[1] ? cell_wave_b : cell_wave_a;
	assign wave_label = step_prev[1] ? cell_wave_b : cell_wave_a;

	// ======================================================================
	// wave front
	// ======================================================================
	always_comb begin
		logic any_new;
		any_new = 1'b0;
		for (int y = 0; y < grid_dim + 2; y++) begin
			wpad[y] = '0;
		end
		for (int y = 0; y < grid_dim; y++) begin
			for (int x = 0; x < grid_dim; x++) begin
				wpad[y+1][x+1] = grid[y][x][1];
			end
		end
		for (int y = 0; y < grid_dim; y++) begin
			for (int x = 0; x < grid_dim; x++) begin
				cand[y][x] = (grid[y][x] == cell_free) &&
				             (wpad[y][x+1] | wpad[y+2][x+1] | wpad[y+1][x] | wpad[y+1][x+2]);
				any_new    = any_new | cand[y][x];
			end
		end
		stalled = !any_new;
	end

	assign end_reached = grid[net.end_pt.y][net.end_pt.x][1];

	// neighbours of the retrace point
	assign nbr_down  = (cur_pt.y == coord_t'(grid_dim - 1)) ? cell_blocked :
	                   grid[cur_pt.y + coord_t'(1)][cur_pt.x];
	assign nbr_up    = (cur_pt.y == '0) ? cell_blocked : grid[cur_pt.y - coord_t'(1)][cur_pt.x];
	assign nbr_right = (cur_pt.x == coord_t'(grid_dim - 1)) ? cell_blocked :
	                   grid[cur_pt.y][cur_pt.x + coord_t'(1)];
	assign nbr_left  = (cur_pt.x == '0) ? cell_blocked : grid[cur_pt.y][cur_pt.x - coord_t'(1)];

	// ======================================================================
	// label updates
	// ======================================================================
	always_ff @(posedge clk) begin
		if (map_we) begin
			for (int x = 0; x < grid_dim; x++) begin
				grid[map_row][x] <= map_blocked[x] ? cell_blocked : cell_free;
			end
		end else if (seed) begin
			grid[net.end_pt.y][net.end_pt.x]     <= cell_free;
			grid[net.start_pt.y][net.start_pt.x] <= cell_wave_a; // wins if start == end
		end else if (grow) begin
			for (int y = 0; y < grid_dim; y++) begin
				for (int x = 0; x < grid_dim; x++) begin
					if (cand[y][x]) grid[y][x] <= grow_label;
				end
			end
		end else if (clear_wave) begin
			for (int y = 0; y < grid_dim; y++) begin
				for (int x = 0; x < grid_dim; x++) begin
					if (grid[y][x][1]) grid[y][x] <= cell_free;
				end
			end
		end else if (mark) begin
			grid[cur_pt.y][cur_pt.x] <= cell_blocked; // path cell
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step <= '0;
		end else if (seed) begin
			step <= '0;
		end else if (grow) begin
			step <= step_next;
		end else if (mark) begin
			step <= step_prev; // retrace walks one ring inwards
		end
	end

endmodule

`default_nettype wire

//--- maze_router_pkg.sv
// shared types for the 16x16 maze router
// grid is indexed [y][x], y grows downwards
// cost_t holds any path sum on this grid without overflow
`default_nettype none

package maze_router_pkg;

	localparam int grid_dim = 16;                 // grid edge length
	localparam int coord_w  = $clog2(grid_dim);
	localparam int weight_w = 4;
	localparam int cost_w   = 12;

	typedef logic [coord_w-1:0]           coord_t;
	typedef logic [weight_w-1:0]          weight_t;
	typedef logic [cost_w-1:0]            cost_t;
	typedef logic [grid_dim-1:0]          row_bits_t;    // bit x is column x
	typedef logic [weight_w*grid_dim-1:0] row_weights_t; // nibble at 4*x is column x

	typedef struct packed {
		coord_t x;
		coord_t y;
	} point_t;

	// bit 1 set means the cell belongs to the current wave
	typedef enum logic [1:0] {
		cell_free    = 2'd0,
		cell_blocked = 2'd1,
		cell_wave_a  = 2'd2, // distance mod 4 is 0 or 1
		cell_wave_b  = 2'd3  // distance mod 4 is 2 or 3
	} cell_t;

	typedef struct packed {
		point_t start_pt;
		point_t end_pt;
	} route_req_t;

	typedef struct packed {
		logic  routed;
		cost_t cost;
	} route_rsp_t;

	typedef enum logic [2:0] {
		st_idle,
		st_seed,
		st_fill,
		st_retrace,
		st_clear,
		st_ack
	} ctrl_state_t;

endpackage

`default_nettype wire
